//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_tx_stream
FILELIST  := list.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard source/*.svh)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)

//--- list.f
+incdir+source
source/tx_sample_pkg.sv
source/tx_cmd_pkg.sv
source/iq_word_assembler.sv
source/iq_sample_fifo.sv
source/dac_sample_pacer.sv
source/tx_cmd_decoder.sv
source/tx_stream_top.sv
tb/tb_clock_gen.sv
tb/tb_stream_assert.sv
tb/tb_tx_stream.sv

//--- source/dac_sample_pacer.sv
// DAC sample pacer
// Pops one word per rate period and splits it into I and Q for the DAC

`timescale 1ns/1ps

module dac_sample_pacer (
  input  logic                    pi_tx_clk,
  input  logic                    arst_n,
  input  logic                    tx_on,
  input  logic                    empty,
  input  logic                    status_clear,
  input  tx_sample_pkg::rate_t    rate,
  input  tx_sample_pkg::iq_word_t head,
  output logic                    pop,
  output tx_sample_pkg::iq_comp_t dac_i,
  output tx_sample_pkg::iq_comp_t dac_q,
  output logic                    dac_strobe,
  output logic                    underflow
);

  tx_sample_pkg::rate_t period_cnt;
  tx_sample_pkg::rate_t eff_rate;
  logic                 period_end;
  logic                 strobe_q;

  // Rate 0 runs at full speed like rate 1
  assign eff_rate = (rate == '0) ? tx_sample_pkg::rate_t'(1) : rate;

  // Greater-or-equal covers a rate lowered mid-period
  assign period_end = tx_on & (period_cnt >= eff_rate - tx_sample_pkg::rate_t'(1));
  assign pop        = period_end & ~empty;

  // ------------------------------
  // Period counter and flags
  // ------------------------------
  always_ff @(posedge pi_tx_clk or negedge arst_n) begin
    if (!arst_n) begin
      period_cnt <= '0;
      strobe_q   <= 1'b0;
      underflow  <= 1'b0;
    end else begin
      if (!tx_on || period_end) begin
        period_cnt <= '0;
      end else begin
        period_cnt <= period_cnt + 1'b1;
      end
      strobe_q <= pop;
      // Starved period is sticky until cleared
      if (period_end && empty) begin
        underflow <= 1'b1;
      end else if (status_clear) begin
        underflow <= 1'b0;
      end
    end
  end

  // I from upper half, Q from lower half
  always_ff @(posedge pi_tx_clk) begin
    if (pop) begin
      dac_i <= head[31:16];
      dac_q <= head[15:0];
    end
  end

  // Suppress a sample popped on the edge where push-to-talk dropped
  assign dac_strobe = strobe_q & tx_on;

endmodule

//--- source/iq_sample_fifo.sv
// IQ sample FIFO
// Single-clock word buffer with flush, fill count and sticky overflow

`timescale 1ns/1ps

`include "tx_stream_config.svh"

module iq_sample_fifo (
  input  logic                    pi_tx_clk,
  input  logic                    arst_n,
  input  logic                    push,
  input  logic                    pop,
  input  logic                    flush,
  input  logic                    status_clear,
  input  tx_sample_pkg::iq_word_t wr_word,
  output tx_sample_pkg::iq_word_t rd_word,
  output logic                    empty,
  output tx_sample_pkg::fill_t    fill,
  output logic                    overflow
);

  localparam int DEPTH = `TX_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  // Storage
  tx_sample_pkg::iq_word_t mem [DEPTH];

  // Pointers wrap on their own, depth is a power of two
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;

  logic full;
  logic do_wr;
  logic do_rd;

  assign full  = (fill == tx_sample_pkg::fill_t'(DEPTH));
  assign empty = (fill == '0);

  // Writes to a full buffer are dropped
  assign do_wr = push & ~full;
  assign do_rd = pop & ~empty;

  // ------------------------------
  // Pointers, fill and flag
  // ------------------------------
  always_ff @(posedge pi_tx_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fill     <= '0;
      overflow <= 1'b0;
    end else begin
      if (flush) begin
        // Drop everything in one cycle
        wr_ptr <= '0;
        rd_ptr <= '0;
        fill   <= '0;
      end else begin
        if (do_wr) begin
          wr_ptr <= wr_ptr + 1'b1;
        end
        if (do_rd) begin
          rd_ptr <= rd_ptr + 1'b1;
        end
        // Fill moves only when one side acts alone
        if (do_wr && !do_rd) begin
          fill <= fill + 1'b1;
        end else if (do_rd && !do_wr) begin
          fill <= fill - 1'b1;
        end
      end
      // New overflow wins over a clear in the same cycle
      if (push && full) begin
        overflow <= 1'b1;
      end else if (status_clear) begin
        overflow <= 1'b0;
      end
    end
  end

  // Storage write
  always_ff @(posedge pi_tx_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_word;
    end
  end

  // Head of queue, available without a read cycle
  assign rd_word = mem[rd_ptr];

endmodule

//--- source/iq_word_assembler.sv
// IQ word assembler
// Packs host nibbles into bytes and bytes into 32-bit IQ words

`timescale 1ns/1ps

module iq_word_assembler (
  input  logic                    pi_tx_clk,
  input  logic                    arst_n,
  input  logic                    tx_on,
  input  tx_sample_pkg::nibble_t  pi_tx_data,
  output tx_sample_pkg::iq_word_t word,
  output logic                    word_strobe
);

  // Nibble position within the word, 0 to 7
  logic [2:0] nib_cnt;

  // Low nibble waiting for its partner
  tx_sample_pkg::nibble_t lo_nib;

  // Byte completed on this cycle's nibble
  tx_sample_pkg::byte_t cur_byte;

  // Bytes shift in from the bottom, first byte ends up in 31:24
  tx_sample_pkg::iq_word_t word_sr;

  // Odd positions carry the high nibble
  assign cur_byte = {pi_tx_data, lo_nib};

  // ------------------------------
  // Nibble counter and strobe
  // ------------------------------
  always_ff @(posedge pi_tx_clk or negedge arst_n) begin
    if (!arst_n) begin
      nib_cnt     <= 3'd0;
      word_strobe <= 1'b0;
    end else if (!tx_on) begin
      // Alignment restarts with the next push-to-talk
      nib_cnt     <= 3'd0;
      word_strobe <= 1'b0;
    end else begin
      nib_cnt     <= nib_cnt + 3'd1;
      // Eighth nibble just taken
      word_strobe <= (nib_cnt == 3'd7);
    end
  end

  // ------------------------------
  // Data path
  // ------------------------------
  always_ff @(posedge pi_tx_clk) begin
    if (tx_on) begin
      if (!nib_cnt[0]) begin
        lo_nib <= pi_tx_data;
      end else begin
        word_sr <= {word_sr[23:0], cur_byte};
      end
    end
  end

  // Shift register holds still during the strobe cycle
  // Next byte only lands two nibbles later
  assign word = word_sr;

endmodule

//--- source/tx_cmd_decoder.sv
// TX command decoder
// Holds push-to-talk and rate from command words, makes clear and flush pulses

`timescale 1ns/1ps

`include "tx_stream_config.svh"

module tx_cmd_decoder (
  input  logic                  pi_tx_clk,
  input  logic                  arst_n,
  input  tx_cmd_pkg::cmd_word_t cmd_word,
  input  logic                  cmd_strobe,
  output logic                  tx_on,
  output tx_sample_pkg::rate_t  rate,
  output logic                  flush,
  output logic                  status_clear
);

  // ------------------------------
  // Field split
  // ------------------------------
  tx_cmd_pkg::cmd_addr_t cmd_addr;
  tx_cmd_pkg::cmd_data_t cmd_data;
  logic                  cmd_ptt;
  logic                  ptt_fall;

  assign cmd_addr = cmd_word[38:33];
  assign cmd_ptt  = cmd_word[32];
  assign cmd_data = cmd_word[31:0];

  // Command drops an active push-to-talk
  assign ptt_fall = cmd_strobe & tx_on & ~cmd_ptt;

  // ------------------------------
  // Command registers
  // ------------------------------
  always_ff @(posedge pi_tx_clk or negedge arst_n) begin
    if (!arst_n) begin
      tx_on        <= 1'b0;
      rate         <= `TX_RATE_DEFAULT;
      flush        <= 1'b0;
      status_clear <= 1'b0;
    end else begin
      // Every command carries push-to-talk
      if (cmd_strobe) begin
        tx_on <= cmd_ptt;
      end
      if (cmd_strobe && cmd_addr == `TX_CMD_ADDR_RATE) begin
        rate <= cmd_data[7:0];
      end
      // Single-cycle pulses
      status_clear <= cmd_strobe & (cmd_addr == `TX_CMD_ADDR_CLEAR);
      // Flush lines up with the first cycle of tx_on low
      flush        <= ptt_fall;
    end
  end

endmodule

//--- source/tx_cmd_pkg.sv
// TX command types
// Command word layout from the host control link and the status word

package tx_cmd_pkg;

  // ------------------------------
  // Command word
  // ------------------------------
  // Bit 39      response request
  // Bits 38:33  address
  // Bit 32      push-to-talk
  // Bits 31:0   data
  typedef logic [39:0] cmd_word_t;

  // Register address field
  typedef logic [5:0] cmd_addr_t;

  // Payload field
  typedef logic [31:0] cmd_data_t;

  // ------------------------------
  // Status word
  // ------------------------------
  // Bits 15:8   version
  // Bit 7       overflow, sticky
  // Bit 6       underflow, sticky
  // Bit 5       zero
  // Bits 4:0    FIFO fill level
  typedef logic [15:0] status_t;

endpackage

//--- source/tx_sample_pkg.sv
// TX sample types
// Widths of the data carried from host nibbles down to DAC components

`include "tx_stream_config.svh"

package tx_sample_pkg;

  // One host transfer on pi_tx_data
  typedef logic [3:0] nibble_t;

  // Two nibbles, low nibble first on the wire
  typedef logic [7:0] byte_t;

  // One complex sample, I in the upper half
  typedef logic [31:0] iq_word_t;

  // Single I or Q value
  typedef logic [15:0] iq_comp_t;

  // FIFO occupancy, 0 up to full depth
  typedef logic [$clog2(`TX_FIFO_DEPTH + 1) - 1:0] fill_t;

  // Clocks per output sample, 0 behaves as 1
  typedef logic [7:0] rate_t;

endpackage

//--- source/tx_stream_config.svh
// TX stream configuration
// Build-time sizes, reset values and command addresses for the ingest path

`ifndef TX_STREAM_CONFIG_SVH
`define TX_STREAM_CONFIG_SVH

// Sample FIFO depth in IQ words, power of two
`define TX_FIFO_DEPTH 16

// Clocks per DAC sample after reset
`define TX_RATE_DEFAULT 8'd1

// Command addresses
`define TX_CMD_ADDR_RATE 6'h01
`define TX_CMD_ADDR_CLEAR 6'h02

// Reported in the top byte of the status word
`define TX_VERSION 8'd68

`endif

//--- source/tx_stream_top.sv
// TX stream top level
// Host nibble ingest, sample FIFO, DAC pacing and command decode

`timescale 1ns/1ps

`include "tx_stream_config.svh"

module tx_stream_top (
  input  logic                    pi_tx_clk,
  input  logic                    arst_n,
  input  tx_sample_pkg::nibble_t  pi_tx_data,
  input  tx_cmd_pkg::cmd_word_t   cmd_word,
  input  logic                    cmd_strobe,
  output logic                    ptt_out,
  output tx_sample_pkg::iq_comp_t dac_i,
  output tx_sample_pkg::iq_comp_t dac_q,
  output logic                    dac_strobe,
  output tx_cmd_pkg::status_t     status
);

  logic                    tx_on;
  tx_sample_pkg::rate_t    rate;
  logic                    flush;
  logic                    status_clear;
  tx_sample_pkg::iq_word_t word;
  logic                    word_strobe;
  tx_sample_pkg::iq_word_t head;
  logic                    pop;
  logic                    empty;
  tx_sample_pkg::fill_t    fill;
  logic                    overflow;
  logic                    underflow;

  // ------------------------------
  // Command path
  // ------------------------------
  tx_cmd_decoder u_cmd (
    .pi_tx_clk    (pi_tx_clk),
    .arst_n       (arst_n),
    .cmd_word     (cmd_word),
    .cmd_strobe   (cmd_strobe),
    .tx_on        (tx_on),
    .rate         (rate),
    .flush        (flush),
    .status_clear (status_clear)
  );

  assign ptt_out = tx_on;

  // ------------------------------
  // Sample path
  // ------------------------------
  iq_word_assembler u_asm (
    .pi_tx_clk   (pi_tx_clk),
    .arst_n      (arst_n),
    .tx_on       (tx_on),
    .pi_tx_data  (pi_tx_data),
    .word        (word),
    .word_strobe (word_strobe)
  );

  iq_sample_fifo u_fifo (
    .pi_tx_clk    (pi_tx_clk),
    .arst_n       (arst_n),
    .push         (word_strobe),
    .pop          (pop),
    .flush        (flush),
    .status_clear (status_clear),
    .wr_word      (word),
    .rd_word      (head),
    .empty        (empty),
    .fill         (fill),
    .overflow     (overflow)
  );

  dac_sample_pacer u_pacer (
    .pi_tx_clk    (pi_tx_clk),
    .arst_n       (arst_n),
    .tx_on        (tx_on),
    .empty        (empty),
    .status_clear (status_clear),
    .rate         (rate),
    .head         (head),
    .pop          (pop),
    .dac_i        (dac_i),
    .dac_q        (dac_q),
    .dac_strobe   (dac_strobe),
    .underflow    (underflow)
  );

  // Version, flags, spare zero, fill in the low 5 bits
  assign status = {`TX_VERSION, overflow, underflow, 1'b0, 5'(fill)};

endmodule

//--- tb/tb_clock_gen.sv
// Testbench clock and reset
// Free-running clock, reset low from time zero for a fixed number of cycles

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Release lands on a falling edge, clear of the sampling edge
  initial begin
    arst_n = 1'b0;
    #(PERIOD_NS * RESET_CYCLES);
    arst_n = 1'b1;
  end

endmodule

//--- tb/tb_stream_assert.sv
// TX stream assertions
// Reset quiet, FIFO bound and DAC strobe gating on the top level

`timescale 1ns/1ps

`include "tx_stream_config.svh"

module tb_stream_assert (
  input logic                 pi_tx_clk,
  input logic                 arst_n,
  input logic                 ptt_out,
  input logic                 dac_strobe,
  input logic                 flush,
  input tx_sample_pkg::fill_t fill
);

  // Nothing strobes while reset is held
  quiet_in_reset: assert property (@(posedge pi_tx_clk)
    !arst_n |-> (!dac_strobe && !flush))
    else $error("dac_strobe or flush high during reset");

  // Occupancy never passes the depth
  fill_in_range: assert property (@(posedge pi_tx_clk) disable iff (!arst_n)
    fill <= tx_sample_pkg::fill_t'(`TX_FIFO_DEPTH))
    else $error("FIFO fill %0d above depth", fill);

  // DAC samples only while transmitting
  strobe_needs_ptt: assert property (@(posedge pi_tx_clk) disable iff (!arst_n)
    !ptt_out |-> !dac_strobe)
    else $error("dac_strobe high with push-to-talk off");

endmodule

bind tx_stream_top tb_stream_assert u_stream_assert (
  .pi_tx_clk  (pi_tx_clk),
  .arst_n     (arst_n),
  .ptt_out    (ptt_out),
  .dac_strobe (dac_strobe),
  .flush      (flush),
  .fill       (fill)
);

//--- tb/tb_tx_stream.sv
// TX stream testbench
// Directed tests of nibble ingest, DAC pacing, FIFO flags and flush

`timescale 1ns/1ps

`include "tx_stream_config.svh"

module tb_tx_stream;

  // ------------------------------
  // Test lengths in clock cycles
  // ------------------------------
  localparam int DEPTH       = `TX_FIFO_DEPTH;
  localparam int N_WORDS     = 6;
  localparam int N_GAPS      = 5;
  localparam int RATE_MID    = 5;
  localparam int RATE_SLOW   = 255;
  localparam int RATE_STARVE = 4;
  // Slower than one word per 8 clocks, samples flow while a backlog builds
  localparam int RATE_DRAIN  = 12;
  localparam int QUIET       = 20;
  localparam int T_ORDER     = N_WORDS * 8 + 60;
  localparam int T_SPACING   = (N_GAPS + 1) * (8 + RATE_MID) + 60;
  localparam int T_OVERFLOW  = (DEPTH + 4) * 8 + 60;
  localparam int T_FLUSH     = RATE_STARVE + 10 * 8 + QUIET + 40;
  localparam int WATCHDOG_CYCLES = 10 + T_ORDER + T_SPACING + T_OVERFLOW + T_FLUSH + 100;
  localparam tx_cmd_pkg::cmd_addr_t ADDR_NONE = 6'h00;

  logic                    pi_tx_clk;
  logic                    arst_n;
  tx_sample_pkg::nibble_t  pi_tx_data;
  tx_cmd_pkg::cmd_word_t   cmd_word;
  logic                    cmd_strobe;
  logic                    ptt_out;
  tx_sample_pkg::iq_comp_t dac_i;
  tx_sample_pkg::iq_comp_t dac_q;
  logic                    dac_strobe;
  tx_cmd_pkg::status_t     status;

  int          num_checks = 0;
  int          num_errors = 0;
  int          cycle      = 0;
  logic [31:0] lcg_state  = 32'd33152;

  // Captured DAC samples with their cycle stamps
  tx_sample_pkg::iq_comp_t got_i[$];
  tx_sample_pkg::iq_comp_t got_q[$];
  int                      got_cyc[$];

  tb_clock_gen u_clk (.clk(pi_tx_clk), .arst_n(arst_n));

  tx_stream_top uut (
    .pi_tx_clk  (pi_tx_clk),
    .arst_n     (arst_n),
    .pi_tx_data (pi_tx_data),
    .cmd_word   (cmd_word),
    .cmd_strobe (cmd_strobe),
    .ptt_out    (ptt_out),
    .dac_i      (dac_i),
    .dac_q      (dac_q),
    .dac_strobe (dac_strobe),
    .status     (status)
  );

  always @(posedge pi_tx_clk) begin
    cycle <= cycle + 1;
  end

  // Samples taken mid-cycle, away from the active edge
  always @(negedge pi_tx_clk) begin
    if (arst_n && dac_strobe) begin
      got_i.push_back(dac_i);
      got_q.push_back(dac_q);
      got_cyc.push_back(cycle);
    end
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] cur);
    return cur * 32'd1664525 + 32'd1013904223;
  endfunction

  // Version on top, then overflow, underflow, a zero and the fill
  function automatic tx_cmd_pkg::status_t expect_status(input logic ovf, input logic unf,
                                                        input int fill);
    tx_cmd_pkg::status_t s;
    s      = tx_cmd_pkg::status_t'(`TX_VERSION) << 8;
    s[7]   = ovf;
    s[6]   = unf;
    s[4:0] = fill[4:0];
    return s;
  endfunction

  task automatic compare_comp(input string name, input tx_sample_pkg::iq_comp_t exp,
                              input tx_sample_pkg::iq_comp_t act);
    num_checks++;
    if (act !== exp) begin
      num_errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic compare_status(input string name, input tx_cmd_pkg::status_t exp,
                                input tx_cmd_pkg::status_t act);
    num_checks++;
    if (act !== exp) begin
      num_errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    num_checks++;
    if (act !== exp) begin
      num_errors++;
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // Clocks between samples
  task automatic compare_rate(input string name, input tx_sample_pkg::rate_t exp,
                              input tx_sample_pkg::rate_t act);
    num_checks++;
    if (act !== exp) begin
      num_errors++;
      $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  // One-cycle command strobe, returns on the edge that takes it
  task automatic send_cmd(input tx_cmd_pkg::cmd_addr_t addr, input logic ptt,
                          input tx_cmd_pkg::cmd_data_t data);
    @(posedge pi_tx_clk);
    cmd_word   <= {1'b0, addr, ptt, data};
    cmd_strobe <= 1'b1;
    @(posedge pi_tx_clk);
    cmd_strobe <= 1'b0;
  endtask

  // Decoder pulse, then FIFO and flags
  task automatic settle();
    repeat (2) @(posedge pi_tx_clk);
    @(negedge pi_tx_clk);
  endtask

  task automatic clear_capture();
    got_i.delete();
    got_q.delete();
    got_cyc.delete();
  endtask

  task automatic wait_samples(input string name, input int count, input int limit);
    int waited;
    waited = 0;
    while (got_i.size() < count && waited < limit) begin
      @(negedge pi_tx_clk);
      waited++;
    end
    if (got_i.size() < count) begin
      num_errors++;
      $display("%s: only %0d of %0d DAC samples within %0d cycles",
               name, got_i.size(), count, limit);
    end
  endtask

  task automatic wait_fill(input string name, input int min_fill, input int limit);
    int waited;
    waited = 0;
    @(negedge pi_tx_clk);
    while (int'(status[4:0]) < min_fill && waited < limit) begin
      @(negedge pi_tx_clk);
      waited++;
    end
    if (int'(status[4:0]) < min_fill) begin
      num_errors++;
      $display("%s: FIFO fill never reached %0d within %0d cycles", name, min_fill, limit);
    end
  endtask

  task automatic wait_overflow(input int limit);
    int waited;
    waited = 0;
    @(negedge pi_tx_clk);
    while (!status[7] && waited < limit) begin
      @(negedge pi_tx_clk);
      waited++;
    end
    if (!status[7]) begin
      num_errors++;
      $display("overflow flag never set within %0d cycles", limit);
    end
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------
  task automatic check_reset_state();
    compare_bit("reset ptt_out", 1'b0, ptt_out);
    compare_bit("reset dac_strobe", 1'b0, dac_strobe);
    compare_status("reset status", expect_status(1'b0, 1'b0, 0), status);
  endtask

  task automatic stream_word_order();
    tx_sample_pkg::nibble_t  nibs[N_WORDS * 8];
    tx_sample_pkg::iq_word_t exp_words[N_WORDS];
    int                      w;
    int                      k;
    for (w = 0; w < N_WORDS; w++) begin
      for (k = 0; k < 8; k++) begin
        lcg_state = lcg_next(lcg_state);
        nibs[w * 8 + k] = lcg_state[27:24];
      end
      // Low nibble first in each byte, first byte on top
      exp_words[w] = {nibs[w * 8 + 1], nibs[w * 8], nibs[w * 8 + 3], nibs[w * 8 + 2],
                      nibs[w * 8 + 5], nibs[w * 8 + 4], nibs[w * 8 + 7], nibs[w * 8 + 6]};
    end
    clear_capture();
    send_cmd(ADDR_NONE, 1'b1, '0);
    // First nibble meets the first cycle with push-to-talk on
    for (k = 0; k < N_WORDS * 8; k++) begin
      pi_tx_data <= nibs[k];
      @(posedge pi_tx_clk);
    end
    pi_tx_data <= '0;
    wait_samples("word_order", N_WORDS, T_ORDER);
    for (w = 0; w < N_WORDS && w < got_i.size(); w++) begin
      compare_comp($sformatf("word_order I%0d", w), exp_words[w][31:16], got_i[w]);
      compare_comp($sformatf("word_order Q%0d", w), exp_words[w][15:0], got_q[w]);
    end
    send_cmd(ADDR_NONE, 1'b0, '0);
    settle();
  endtask

  task automatic pace_at_rate_five();
    int k;
    // Slow pacer first so the FIFO builds a backlog
    send_cmd(`TX_CMD_ADDR_RATE, 1'b1, tx_cmd_pkg::cmd_data_t'(RATE_SLOW));
    wait_fill("rate_spacing", N_GAPS + 1, T_SPACING);
    clear_capture();
    send_cmd(`TX_CMD_ADDR_RATE, 1'b1, tx_cmd_pkg::cmd_data_t'(RATE_MID));
    wait_samples("rate_spacing", N_GAPS + 1, T_SPACING);
    for (k = 1; k <= N_GAPS && k < got_cyc.size(); k++) begin
      compare_rate($sformatf("rate_spacing gap%0d", k), tx_sample_pkg::rate_t'(RATE_MID),
                   tx_sample_pkg::rate_t'(got_cyc[k] - got_cyc[k - 1]));
    end
    send_cmd(ADDR_NONE, 1'b0, '0);
    settle();
  endtask

  task automatic fill_to_overflow();
    send_cmd(`TX_CMD_ADDR_CLEAR, 1'b0, '0);
    settle();
    compare_status("overflow start", expect_status(1'b0, 1'b0, 0), status);
    send_cmd(`TX_CMD_ADDR_RATE, 1'b1, tx_cmd_pkg::cmd_data_t'(RATE_SLOW));
    wait_overflow(T_OVERFLOW);
    compare_status("overflow full", expect_status(1'b1, 1'b0, DEPTH), status);
    // Flush empties the FIFO but the flag stays
    send_cmd(ADDR_NONE, 1'b0, '0);
    settle();
    compare_status("overflow flushed", expect_status(1'b1, 1'b0, 0), status);
    send_cmd(`TX_CMD_ADDR_CLEAR, 1'b0, '0);
    settle();
    compare_status("overflow cleared", expect_status(1'b0, 1'b0, 0), status);
  endtask

  task automatic starve_and_flush();
    send_cmd(`TX_CMD_ADDR_RATE, 1'b0, tx_cmd_pkg::cmd_data_t'(RATE_STARVE));
    send_cmd(ADDR_NONE, 1'b1, '0);
    // Period counter starts at zero, first period ends RATE_STARVE edges on
    repeat (RATE_STARVE - 1) @(posedge pi_tx_clk);
    @(negedge pi_tx_clk);
    compare_bit("underflow early", 1'b0, status[6]);
    @(negedge pi_tx_clk);
    compare_bit("underflow one period", 1'b1, status[6]);
    // DAC keeps running while the backlog grows
    clear_capture();
    send_cmd(`TX_CMD_ADDR_RATE, 1'b1, tx_cmd_pkg::cmd_data_t'(RATE_DRAIN));
    wait_fill("flush", 3, T_FLUSH);
    compare_bit("flush samples before", 1'b1, got_i.size() != 0);
    send_cmd(ADDR_NONE, 1'b0, '0);
    settle();
    compare_status("flush status", expect_status(1'b0, 1'b1, 0), status);
    clear_capture();
    repeat (QUIET) @(negedge pi_tx_clk);
    compare_bit("flush dac_strobe", 1'b0, dac_strobe);
    compare_bit("flush samples", 1'b0, got_i.size() != 0);
  endtask

  // ------------------------------
  // Sequence and watchdog
  // ------------------------------
  initial begin
    pi_tx_data = '0;
    cmd_word   = '0;
    cmd_strobe = 1'b0;
    wait (arst_n === 1'b1);
    @(negedge pi_tx_clk);
    check_reset_state();
    stream_word_order();
    pace_at_rate_five();
    fill_to_overflow();
    starve_and_flush();
    $display("Checks run: %0d, errors: %0d", num_checks, num_errors);
    if (num_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge pi_tx_clk);
    $display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule
